/* rtl/layer_config.svh */
`ifndef LAYER_CONFIG_SVH
`define LAYER_CONFIG_SVH

// Layer geometry
`define INPUT_COUNT 10
`define NEURON_COUNT 4

// Fixed-point format, Q13 with 16-bit results
`define DATA_WIDTH 32
`define FRAC_BITS 13
`define OUT_WIDTH 16

`define APB_ADDR_WIDTH 12

// Register map, byte addresses
`define ACT_BASE 12'h000
`define CTRL_ADDR 12'h080
`define STATUS_ADDR 12'h084
`define RESULT_BASE 12'h0C0
`define WEIGHT_BASE 12'h100
`define WEIGHT_BLOCK_WORDS 16 // Words 0-9 weights, word 10 bias

`endif

/* rtl/nnTypesPkg.sv */
`default_nettype none

`include "layer_config.svh"

package nnTypesPkg;

	// Two's complement Q13 word, arithmetic wraps
	typedef logic signed [`DATA_WIDTH-1:0] dataWord_t;

	typedef dataWord_t [`INPUT_COUNT-1:0] actVector_t;

	// Run-time loaded coefficients of one neuron
	typedef struct packed
	{
		actVector_t weights;
		dataWord_t bias;
	} neuronParams_t;

	typedef logic [`OUT_WIDTH-1:0] neuronOut_t; // After ReLU, never negative

	typedef neuronOut_t [`NEURON_COUNT-1:0] layerOut_t;

endpackage

`default_nettype wire

/* rtl/apbPkg.sv */
`default_nettype none

`include "layer_config.svh"

package apbPkg;

	typedef logic [`APB_ADDR_WIDTH-1:0] apbAddr_t;
	typedef logic [`DATA_WIDTH-1:0] apbData_t;

	// Master to slave
	typedef struct packed
	{
		logic psel;
		logic penable;
		logic pwrite;
		apbAddr_t paddr;
		apbData_t pwdata;
	} apbReq_t;

	// Slave to master, valid in the access cycle
	typedef struct packed
	{
		apbData_t prdata;
		logic pready;
		logic pslverr;
	} apbResp_t;

endpackage

`default_nettype wire

/* rtl/layerRegs.sv */
`default_nettype none

`include "layer_config.svh"

module layerRegs
	import nnTypesPkg::*, apbPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire apbReq_t apbReq,
	output apbResp_t apbResp,
	input wire layerOut_t results,
	input wire logic done,
	output actVector_t activations,
	output neuronParams_t params [`NEURON_COUNT],
	output logic start,
	output logic clearDone
);

	localparam int WordBits = `APB_ADDR_WIDTH - 2;
	localparam int ActIdxBits = $clog2(`INPUT_COUNT);
	localparam int NeuronBits = $clog2(`NEURON_COUNT);
	localparam int SlotBits = $clog2(`WEIGHT_BLOCK_WORDS);

	localparam logic [WordBits-1:0] ActWord = WordBits'(`ACT_BASE >> 2);
	localparam logic [WordBits-1:0] CtrlWord = WordBits'(`CTRL_ADDR >> 2);
	localparam logic [WordBits-1:0] StatusWord = WordBits'(`STATUS_ADDR >> 2);
	localparam logic [WordBits-1:0] ResultWord = WordBits'(`RESULT_BASE >> 2);
	localparam logic [WordBits-1:0] WeightWord = WordBits'(`WEIGHT_BASE >> 2);

	logic access;
	logic writeEn;
	logic [WordBits-1:0] wordAddr;
	logic [WordBits-1:0] actOffset;
	logic [WordBits-1:0] resOffset;
	logic [WordBits-1:0] weightOffset;
	logic [ActIdxBits-1:0] actIdx;
	logic [NeuronBits-1:0] resIdx;
	logic [NeuronBits-1:0] neuronIdx;
	logic [SlotBits-1:0] slot;
	logic isAct;
	logic isCtrl;
	logic isStatus;
	logic isResult;
	logic inWeightBlock;
	logic isWeight;
	logic isBias;
	logic mapped;
	logic accessError;
	dataWord_t readData;

	assign access = apbReq.psel && apbReq.penable;
	assign wordAddr = apbReq.paddr[`APB_ADDR_WIDTH-1:2]; // Byte lanes ignored

	// Offsets wrap below each base, so one compare bounds both ends
	assign actOffset = wordAddr - ActWord;
	assign resOffset = wordAddr - ResultWord;
	assign weightOffset = wordAddr - WeightWord;

	assign actIdx = actOffset[ActIdxBits-1:0];
	assign resIdx = resOffset[NeuronBits-1:0];
	assign slot = weightOffset[SlotBits-1:0];
	assign neuronIdx = weightOffset[SlotBits +: NeuronBits];

	assign isAct = actOffset < WordBits'(`INPUT_COUNT);
	assign isCtrl = wordAddr == CtrlWord;
	assign isStatus = wordAddr == StatusWord;
	assign isResult = resOffset < WordBits'(`NEURON_COUNT);
	assign inWeightBlock = weightOffset < WordBits'(`NEURON_COUNT * `WEIGHT_BLOCK_WORDS);
	assign isWeight = inWeightBlock && (slot < SlotBits'(`INPUT_COUNT));
	assign isBias = inWeightBlock && (slot == SlotBits'(`INPUT_COUNT));

	assign mapped = isAct || isCtrl || isStatus || isResult || isWeight || isBias;
	// Status and results are read only
	assign accessError = !mapped || (apbReq.pwrite && (isStatus || isResult));
	assign writeEn = access && apbReq.pwrite && !accessError;

	always_comb
	begin
		readData = '0; // CTRL reads back 0
		if (isAct)
			readData = activations[actIdx];
		else if (isStatus)
			readData = dataWord_t'(done);
		else if (isResult)
			readData = dataWord_t'(results[resIdx]);
		else if (isWeight)
			readData = params[neuronIdx].weights[slot];
		else if (isBias)
			readData = params[neuronIdx].bias;
	end

	assign apbResp.prdata = (access && !apbReq.pwrite) ? readData : '0;
	assign apbResp.pready = 1'b1; // No wait states
	assign apbResp.pslverr = access && accessError;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activations <= '0;
			params <= '{default: '0};
			start <= 1'b0;
		end
		else
		begin
			start <= writeEn && isCtrl && apbReq.pwdata[0];
			if (writeEn && isAct)
				activations[actIdx] <= apbReq.pwdata;
			if (writeEn && isWeight)
				params[neuronIdx].weights[slot] <= apbReq.pwdata;
			if (writeEn && isBias)
				params[neuronIdx].bias <= apbReq.pwdata;
		end
	end

	// Same edge that launches the neurons also drops the old done
	assign clearDone = start;

	penableNeedsPsel: assert property (@(posedge clk) disable iff (reset)
		apbReq.penable |-> apbReq.psel);

	startIsPulse: assert property (@(posedge clk) disable iff (reset)
		start |=> !start);

endmodule

`default_nettype wire

/* rtl/neuron.sv */
`default_nettype none

`include "layer_config.svh"

module neuron
	import nnTypesPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire actVector_t activations,
	input wire neuronParams_t params,
	output neuronOut_t result,
	output logic valid
);

	actVector_t actReg;
	dataWord_t sumReg;
	dataWord_t weightedSum;
	logic captureValid;
	logic sumValid;

	// Products and sum keep only the low DATA_WIDTH bits
	always_comb
	begin
		weightedSum = params.bias;
		for (int i = 0; i < `INPUT_COUNT; i++)
			weightedSum += actReg[i] * params.weights[i];
	end

	// Valid bit follows the data through all three stages
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			captureValid <= 1'b0;
			sumValid <= 1'b0;
			valid <= 1'b0;
		end
		else
		begin
			captureValid <= start;
			sumValid <= captureValid;
			valid <= sumValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			actReg <= activations; // Stage 1
		sumReg <= weightedSum; // Stage 2

		// Stage 3, ReLU then drop the fraction bits
		if (sumReg[`DATA_WIDTH-1])
			result <= '0;
		else
			result <= sumReg[`FRAC_BITS+`OUT_WIDTH-1:`FRAC_BITS];
	end

endmodule

`default_nettype wire

/* rtl/resultCollector.sv */
`default_nettype none

`include "layer_config.svh"

module resultCollector
	import nnTypesPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic [`NEURON_COUNT-1:0] valid,
	input wire layerOut_t results,
	input wire logic clearDone,
	output layerOut_t layerResults,
	output logic done
);

	logic anyValid;

	assign anyValid = |valid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			layerResults <= '0;
			done <= 1'b0;
		end
		else
		begin
			for (int n = 0; n < `NEURON_COUNT; n++)
			begin
				if (valid[n])
					layerResults[n] <= results[n];
			end
			// A completion wins over a clear in the same cycle
			if (anyValid)
				done <= 1'b1;
			else if (clearDone)
				done <= 1'b0;
		end
	end

	// All neurons share one start, so they finish together
	validInLockstep: assert property (@(posedge clk) disable iff (reset)
		(valid == '0) || (valid == '1));

endmodule

`default_nettype wire

/* rtl/denseLayer.sv */
`default_nettype none

`include "layer_config.svh"

module denseLayer
	import nnTypesPkg::*, apbPkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire apbReq_t apbReq,
	output apbResp_t apbResp
);

	actVector_t activations;
	neuronParams_t params [`NEURON_COUNT];
	logic start;
	logic clearDone;
	logic done;
	logic [`NEURON_COUNT-1:0] neuronValid;
	layerOut_t neuronResults;
	layerOut_t layerResults;

	layerRegs regs (
		.clk(clk),
		.reset(reset),
		.apbReq(apbReq),
		.apbResp(apbResp),
		.results(layerResults),
		.done(done),
		.activations(activations),
		.params(params),
		.start(start),
		.clearDone(clearDone)
	);

	for (genvar n = 0; n < `NEURON_COUNT; n++)
	begin : neurons
		neuron unit (
			.clk(clk),
			.reset(reset),
			.start(start),
			.activations(activations), // Shared by every neuron
			.params(params[n]),
			.result(neuronResults[n]),
			.valid(neuronValid[n])
		);
	end

	resultCollector collector (
		.clk(clk),
		.reset(reset),
		.valid(neuronValid),
		.results(neuronResults),
		.clearDone(clearDone),
		.layerResults(layerResults),
		.done(done)
	);

endmodule

`default_nettype wire

/* testbench/denseLayerTb.sv */
`default_nettype none

`include "layer_config.svh"

module denseLayerTb
	import nnTypesPkg::*, apbPkg::*;
();

	localparam int Rounds = 50;
	localparam int MaxPolls = 20;
	localparam int CycleLimit = Rounds * 300 + 5000; // About 200 cycles per random round

	logic clk;
	logic reset;
	apbReq_t apbReq;
	apbResp_t apbResp;

	int seed = 32'hc19ace85;
	int cycleCount = 0;

	// Shadow copy of what the DUT should hold
	int acts[`INPUT_COUNT];
	int weights[`NEURON_COUNT][`INPUT_COUNT];
	int biases[`NEURON_COUNT];

	denseLayer DUT (
		.clk(clk),
		.reset(reset),
		.apbReq(apbReq),
		.apbResp(apbResp)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= CycleLimit)
		begin
			$display("Timeout: simulation ran past %0d cycles", CycleLimit);
			$display("TB FAILED");
			$fatal(1);
		end
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
			failRun($sformatf("** Error: %s expected 0x%08h actual 0x%08h",
				testName, expected, actual));
	endtask

	task automatic checkFlag(input string testName, input logic expected, input logic actual);
		assert (actual === expected)
		else
			failRun($sformatf("** Error: %s expected %0b actual %0b", testName, expected, actual));
	endtask

	// Setup and access phase, response sampled mid access cycle
	task automatic apbAccess(input bit isWrite, input int addr, input int wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#2;
		apbReq.psel = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite = isWrite;
		apbReq.paddr = addr[`APB_ADDR_WIDTH-1:0];
		apbReq.pwdata = wdata;
		@(posedge clk);
		#2;
		apbReq.penable = 1'b1;
		@(negedge clk);
		rdata = apbResp.prdata;
		err = apbResp.pslverr;
		assert (apbResp.pready === 1'b1)
		else
			failRun("APB slave did not raise pready in the access cycle");
		@(posedge clk);
		#2;
		apbReq.psel = 1'b0;
		apbReq.penable = 1'b0;
	endtask

	task automatic apbWrite(input int addr, input int data, output logic err);
		logic [31:0] unused;
		apbAccess(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input int addr, output logic [31:0] data, output logic err);
		apbAccess(1'b0, addr, 0, data, err);
	endtask

	function automatic int randSigned(input int bits);
		int r;
		r = $random(seed);
		return (r <<< (32 - bits)) >>> (32 - bits);
	endfunction

	function automatic int randUnsigned(input int bits);
		int r;
		r = $random(seed);
		return r & ((1 << bits) - 1);
	endfunction

	function automatic int weightAddr(input int n, input int slot);
		return `WEIGHT_BASE + (n * `WEIGHT_BLOCK_WORDS + slot) * 4;
	endfunction

	// Wrapped 32-bit dot product plus bias, ReLU, then drop the fraction
	function automatic int modelResult(input int n);
		int sum;
		sum = biases[n];
		for (int i = 0; i < `INPUT_COUNT; i++)
			sum += acts[i] * weights[n][i];
		if (sum < 0)
			return 0;
		return (sum >> `FRAC_BITS) & 32'h0000ffff;
	endfunction

	task automatic loadParams();
		logic err;
		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			for (int i = 0; i < `INPUT_COUNT; i++)
				apbWrite(weightAddr(n, i), weights[n][i], err);
			apbWrite(weightAddr(n, `INPUT_COUNT), biases[n], err);
		end
	endtask

	task automatic writeAct(input int i);
		logic err;
		apbWrite(`ACT_BASE + i * 4, acts[i], err);
	endtask

	task automatic startEval();
		logic err;
		apbWrite(`CTRL_ADDR, 1, err);
	endtask

	task automatic waitDone(input string testName);
		logic [31:0] status;
		logic err;
		int polls;
		polls = 0;
		do
		begin
			apbRead(`STATUS_ADDR, status, err);
			polls++;
		end
		while (!status[0] && polls < MaxPolls);
		assert (status[0])
		else
			failRun($sformatf("%s: done flag never set after %0d STATUS polls",
				testName, MaxPolls));
	endtask

	task automatic checkResults(input string testName);
		logic [31:0] data;
		logic err;
		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			apbRead(`RESULT_BASE + n * 4, data, err);
			checkValue($sformatf("%s neuron %0d", testName, n), modelResult(n), data);
		end
	endtask

	task automatic runEval(input string testName);
		loadParams();
		for (int i = 0; i < `INPUT_COUNT; i++)
			writeAct(i);
		startEval();
		waitDone(testName);
	endtask

	task automatic evaluate(input string testName);
		runEval(testName);
		checkResults(testName);
	endtask

	task automatic checkResetState();
		logic [31:0] data;
		logic err;
		apbRead(`STATUS_ADDR, data, err);
		checkValue("reset status", 0, data);
		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			apbRead(`RESULT_BASE + n * 4, data, err);
			checkValue("reset result", 0, data);
			apbRead(weightAddr(n, n), data, err);
			checkValue("reset weight", 0, data);
			apbRead(weightAddr(n, `INPUT_COUNT), data, err);
			checkValue("reset bias", 0, data);
		end
	endtask

	task automatic checkErrors();
		logic [31:0] data;
		logic err;
		apbRead(12'h0A0, data, err); // Gap between STATUS and results
		checkFlag("unmapped read", 1'b1, err);
		apbWrite(12'h200, 5, err); // Past the last weight block
		checkFlag("unmapped write", 1'b1, err);
		apbRead(weightAddr(1, `INPUT_COUNT + 1), data, err);
		checkFlag("unused weight slot", 1'b1, err);
		apbWrite(`RESULT_BASE, 7, err);
		checkFlag("result write", 1'b1, err);
		apbWrite(`STATUS_ADDR, 1, err);
		checkFlag("status write", 1'b1, err);
		apbRead(`ACT_BASE, data, err);
		checkFlag("mapped read", 1'b0, err);
		apbWrite(weightAddr(2, 3), 9, err);
		checkFlag("mapped write", 1'b0, err);
	endtask

	initial
	begin
		logic [31:0] data;
		logic err;
		clk = 1'b0;
		reset = 1'b1;
		apbReq = '0;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;

		checkResetState();

		for (int r = 0; r < Rounds; r++)
		begin
			for (int n = 0; n < `NEURON_COUNT; n++)
			begin
				for (int i = 0; i < `INPUT_COUNT; i++)
					weights[n][i] = randSigned(16);
				biases[n] = randSigned(16);
			end
			for (int i = 0; i < `INPUT_COUNT; i++)
				acts[i] = randSigned(16);
			evaluate($sformatf("random round %0d", r));
		end

		// Bias far below anything the small products can reach
		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			for (int i = 0; i < `INPUT_COUNT; i++)
				weights[n][i] = randSigned(8);
			biases[n] = -(1 << 28);
		end
		for (int i = 0; i < `INPUT_COUNT; i++)
			acts[i] = randSigned(8);
		runEval("relu negative");
		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			apbRead(`RESULT_BASE + n * 4, data, err);
			checkValue("relu clamp", 0, data);
		end

		for (int n = 0; n < `NEURON_COUNT; n++)
		begin
			for (int i = 0; i < `INPUT_COUNT; i++)
				weights[n][i] = randUnsigned(8);
			biases[n] = randUnsigned(10);
		end
		for (int i = 0; i < `INPUT_COUNT; i++)
			acts[i] = randUnsigned(8);
		evaluate("relu positive");

		// Second start follows after only two activation writes
		startEval();
		acts[0] = randSigned(16);
		acts[`INPUT_COUNT-1] = randSigned(16);
		writeAct(0);
		writeAct(`INPUT_COUNT - 1);
		startEval();
		waitDone("pipelined starts");
		checkResults("pipelined starts");

		startEval();
		apbRead(`STATUS_ADDR, data, err);
		checkValue("done cleared by start", 0, data);
		waitDone("done clearing");
		checkResults("done clearing");

		checkErrors();

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/nnTypesPkg.sv
rtl/apbPkg.sv
rtl/layerRegs.sv
rtl/neuron.sv
rtl/resultCollector.sv
rtl/denseLayer.sv
testbench/denseLayerTb.sv

/* run.sh */
#!/bin/sh
# Builds the dense layer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module denseLayerTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VdenseLayerTb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
